//--- rtl/jtag_dbg_macros.svh
// Fixed widths of the debug port. The IR width must match the opcode values in the package
`ifndef JTAG_DBG_MACROS_SVH
`define JTAG_DBG_MACROS_SVH

// Instruction register
`define JTAG_IR_WIDTH 5

// Longest data register, sets the shift path width
`define JTAG_DR_WIDTH 32

// Device ID, bit 0 must stay set
`define JTAG_IDCODE 32'h0DB6_C0D1

// User register widths, none wider than the DR
`define JTAG_USER0_W 8
`define JTAG_USER1_W 16
`define JTAG_USER2_W 24
`define JTAG_USER3_W 32

`endif

//--- rtl/jtag_dbg_pkg.sv
// TAP state and instruction types. The opcode width follows the macro header
`include "jtag_dbg_macros.svh"

package jtag_dbg_pkg;

    //////////////////////////////////////////////////
    // TAP controller states, IEEE 1149.1 order
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'd0,
        RUN_TEST_IDLE    = 4'd1,
        SELECT_DR_SCAN   = 4'd2,
        CAPTURE_DR       = 4'd3,
        SHIFT_DR         = 4'd4,
        EXIT1_DR         = 4'd5,
        PAUSE_DR         = 4'd6,
        EXIT2_DR         = 4'd7,
        UPDATE_DR        = 4'd8,
        SELECT_IR_SCAN   = 4'd9,
        CAPTURE_IR       = 4'd10,
        SHIFT_IR         = 4'd11,
        EXIT1_IR         = 4'd12,
        PAUSE_IR         = 4'd13,
        EXIT2_IR         = 4'd14,
        UPDATE_IR        = 4'd15
    } tap_state_e;

    //////////////////////////////////////////////////
    // Instruction codes
    typedef enum logic [`JTAG_IR_WIDTH-1:0] {
        IDCODE = 5'h01,
        USER0  = 5'h10,
        USER1  = 5'h11,
        USER2  = 5'h12,
        USER3  = 5'h13,
        BYPASS = 5'h1F   // Also what unlisted codes decode to
    } ir_opcode_e;

endpackage

//--- rtl/tap_fsm.sv
// TAP controller on TCK. Each strobe is high for the whole of its state, not for one edge only
`timescale 1ns/1ps

module tap_fsm (
    input  logic tck_i,
    input  logic trst_n_i,
    input  logic tms_i,
    output logic logic_reset_o,
    output logic capture_ir_o,
    output logic shift_ir_o,
    output logic update_ir_o,
    output logic capture_dr_o,
    output logic shift_dr_o,
    output logic update_dr_o
);

    jtag_dbg_pkg::tap_state_e state_q;
    jtag_dbg_pkg::tap_state_e state_d;

    //////////////////////////////////////////////////
    // Next state from TMS
    always_comb begin
        case (state_q)
            jtag_dbg_pkg::TEST_LOGIC_RESET:
                state_d = tms_i ? jtag_dbg_pkg::TEST_LOGIC_RESET : jtag_dbg_pkg::RUN_TEST_IDLE;
            jtag_dbg_pkg::RUN_TEST_IDLE:
                state_d = tms_i ? jtag_dbg_pkg::SELECT_DR_SCAN : jtag_dbg_pkg::RUN_TEST_IDLE;
            // DR column
            jtag_dbg_pkg::SELECT_DR_SCAN:
                state_d = tms_i ? jtag_dbg_pkg::SELECT_IR_SCAN : jtag_dbg_pkg::CAPTURE_DR;
            jtag_dbg_pkg::CAPTURE_DR:
                state_d = tms_i ? jtag_dbg_pkg::EXIT1_DR : jtag_dbg_pkg::SHIFT_DR;
            jtag_dbg_pkg::SHIFT_DR:
                state_d = tms_i ? jtag_dbg_pkg::EXIT1_DR : jtag_dbg_pkg::SHIFT_DR;
            jtag_dbg_pkg::EXIT1_DR:
                state_d = tms_i ? jtag_dbg_pkg::UPDATE_DR : jtag_dbg_pkg::PAUSE_DR;
            jtag_dbg_pkg::PAUSE_DR:
                state_d = tms_i ? jtag_dbg_pkg::EXIT2_DR : jtag_dbg_pkg::PAUSE_DR;
            jtag_dbg_pkg::EXIT2_DR:
                state_d = tms_i ? jtag_dbg_pkg::UPDATE_DR : jtag_dbg_pkg::SHIFT_DR;
            jtag_dbg_pkg::UPDATE_DR:
                state_d = tms_i ? jtag_dbg_pkg::SELECT_DR_SCAN : jtag_dbg_pkg::RUN_TEST_IDLE;
            // IR column
            jtag_dbg_pkg::SELECT_IR_SCAN:
                state_d = tms_i ? jtag_dbg_pkg::TEST_LOGIC_RESET : jtag_dbg_pkg::CAPTURE_IR;
            jtag_dbg_pkg::CAPTURE_IR:
                state_d = tms_i ? jtag_dbg_pkg::EXIT1_IR : jtag_dbg_pkg::SHIFT_IR;
            jtag_dbg_pkg::SHIFT_IR:
                state_d = tms_i ? jtag_dbg_pkg::EXIT1_IR : jtag_dbg_pkg::SHIFT_IR;
            jtag_dbg_pkg::EXIT1_IR:
                state_d = tms_i ? jtag_dbg_pkg::UPDATE_IR : jtag_dbg_pkg::PAUSE_IR;
            jtag_dbg_pkg::PAUSE_IR:
                state_d = tms_i ? jtag_dbg_pkg::EXIT2_IR : jtag_dbg_pkg::PAUSE_IR;
            jtag_dbg_pkg::EXIT2_IR:
                state_d = tms_i ? jtag_dbg_pkg::UPDATE_IR : jtag_dbg_pkg::SHIFT_IR;
            jtag_dbg_pkg::UPDATE_IR:
                state_d = tms_i ? jtag_dbg_pkg::SELECT_DR_SCAN : jtag_dbg_pkg::RUN_TEST_IDLE;
            default:
                state_d = jtag_dbg_pkg::TEST_LOGIC_RESET;
        endcase
    end

    always_ff @(posedge tck_i or negedge trst_n_i) begin
        if (!trst_n_i) begin
            state_q <= jtag_dbg_pkg::TEST_LOGIC_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////
    // State decode, the only place the state is tested
    assign logic_reset_o = (state_q == jtag_dbg_pkg::TEST_LOGIC_RESET);
    assign capture_ir_o  = (state_q == jtag_dbg_pkg::CAPTURE_IR);
    assign shift_ir_o    = (state_q == jtag_dbg_pkg::SHIFT_IR);
    assign update_ir_o   = (state_q == jtag_dbg_pkg::UPDATE_IR);
    assign capture_dr_o  = (state_q == jtag_dbg_pkg::CAPTURE_DR);
    assign shift_dr_o    = (state_q == jtag_dbg_pkg::SHIFT_DR);
    assign update_dr_o   = (state_q == jtag_dbg_pkg::UPDATE_DR);

endmodule

//--- rtl/tap_ir.sv
// Capture-IR loads the current instruction, not the IEEE 01 pattern. Unlisted codes act as BYPASS
`timescale 1ns/1ps
`include "jtag_dbg_macros.svh"

module tap_ir (
    input  logic                     tck_i,
    input  logic                     trst_n_i,
    input  logic                     tdi_i,
    input  logic                     logic_reset_i,
    input  logic                     capture_ir_i,
    input  logic                     shift_ir_i,
    input  logic                     update_ir_i,
    output logic                     ir_lsb_o,
    output jtag_dbg_pkg::ir_opcode_e opcode_o
);

    logic [`JTAG_IR_WIDTH-1:0] ir_shift_q;   // Scan chain
    logic [`JTAG_IR_WIDTH-1:0] ir_q;         // Raw instruction, kept for readback

    always_ff @(posedge tck_i) begin
        if (capture_ir_i) begin
            ir_shift_q <= ir_q;
        end else if (shift_ir_i) begin
            ir_shift_q <= {tdi_i, ir_shift_q[`JTAG_IR_WIDTH-1:1]};   // LSB out first
        end
    end

    always_ff @(posedge tck_i or negedge trst_n_i) begin
        if (!trst_n_i) begin
            ir_q <= jtag_dbg_pkg::IDCODE;
        end else if (logic_reset_i) begin
            ir_q <= jtag_dbg_pkg::IDCODE;
        end else if (update_ir_i) begin
            ir_q <= ir_shift_q;
        end
    end

    assign ir_lsb_o = ir_shift_q[0];

    // Legal codes pass, the rest fold to BYPASS
    always_comb begin
        case (ir_q)
            jtag_dbg_pkg::IDCODE, jtag_dbg_pkg::USER0, jtag_dbg_pkg::USER1,
            jtag_dbg_pkg::USER2, jtag_dbg_pkg::USER3, jtag_dbg_pkg::BYPASS:
                opcode_o = jtag_dbg_pkg::ir_opcode_e'(ir_q);
            default:
                opcode_o = jtag_dbg_pkg::BYPASS;
        endcase
    end

endmodule

//--- rtl/tap_dr.sv
// Shift path is 32 bits wide. Bits above the selected length hold their value during Shift-DR
`timescale 1ns/1ps
`include "jtag_dbg_macros.svh"

module tap_dr (
    input  logic                         tck_i,
    input  logic                         trst_n_i,
    input  logic                         tdi_i,
    input  jtag_dbg_pkg::ir_opcode_e     opcode_i,
    input  logic                         capture_dr_i,
    input  logic                         shift_dr_i,
    input  logic                         shift_ir_i,
    input  logic                         ir_lsb_i,
    input  logic [`JTAG_DR_WIDTH-1:0]    user_rd_data_i,
    output logic [`JTAG_DR_WIDTH-1:0]    shift_data_o,
    output logic                         tdo_o
);

    logic [`JTAG_DR_WIDTH-1:0] dr_q;
    logic [`JTAG_DR_WIDTH-1:0] dr_shifted;
    logic [`JTAG_DR_WIDTH-1:0] dr_capture;
    logic [`JTAG_DR_WIDTH-1:0] dr_right;
    logic [5:0]                dr_len;       // Active chain length, 1 to 32

    //////////////////////////////////////////////////
    // Length and capture source per instruction
    always_comb begin
        case (opcode_i)
            jtag_dbg_pkg::IDCODE: begin
                dr_len     = 6'(`JTAG_DR_WIDTH);
                dr_capture = `JTAG_IDCODE;
            end
            jtag_dbg_pkg::USER0: begin
                dr_len     = 6'(`JTAG_USER0_W);
                dr_capture = user_rd_data_i;
            end
            jtag_dbg_pkg::USER1: begin
                dr_len     = 6'(`JTAG_USER1_W);
                dr_capture = user_rd_data_i;
            end
            jtag_dbg_pkg::USER2: begin
                dr_len     = 6'(`JTAG_USER2_W);
                dr_capture = user_rd_data_i;
            end
            jtag_dbg_pkg::USER3: begin
                dr_len     = 6'(`JTAG_USER3_W);
                dr_capture = user_rd_data_i;
            end
            default: begin                       // BYPASS, single zero bit
                dr_len     = 6'd1;
                dr_capture = '0;
            end
        endcase
    end

    // Shift right inside the active length, TDI enters at length-1
    assign dr_right = {tdi_i, dr_q[`JTAG_DR_WIDTH-1:1]};

    always_comb begin
        for (int i = 0; i < `JTAG_DR_WIDTH; i++) begin
            if (i == int'(dr_len) - 1) begin
                dr_shifted[i] = tdi_i;
            end else if (i < int'(dr_len) - 1) begin
                dr_shifted[i] = dr_right[i];
            end else begin
                dr_shifted[i] = dr_q[i];
            end
        end
    end

    always_ff @(posedge tck_i) begin
        if (capture_dr_i) begin
            dr_q <= dr_capture;
        end else if (shift_dr_i) begin
            dr_q <= dr_shifted;
        end
    end

    assign shift_data_o = dr_q;

    //////////////////////////////////////////////////
    // TDO on falling edge, valid at next rising edge
    always_ff @(negedge tck_i or negedge trst_n_i) begin
        if (!trst_n_i) begin
            tdo_o <= 1'b0;
        end else if (shift_ir_i) begin
            tdo_o <= ir_lsb_i;
        end else if (shift_dr_i) begin
            tdo_o <= dr_q[0];
        end else begin
            tdo_o <= 1'b0;
        end
    end

endmodule

//--- rtl/user_regs.sv
// Written only at Update-DR of a USERn instruction. Cleared by TRST and not by Test-Logic-Reset
`timescale 1ns/1ps
`include "jtag_dbg_macros.svh"

module user_regs (
    input  logic                         tck_i,
    input  logic                         trst_n_i,
    input  jtag_dbg_pkg::ir_opcode_e     opcode_i,
    input  logic                         update_dr_i,
    input  logic [`JTAG_DR_WIDTH-1:0]    shift_data_i,
    output logic [`JTAG_DR_WIDTH-1:0]    user_rd_data_o,
    output logic [`JTAG_USER0_W-1:0]     user0_o,
    output logic [`JTAG_USER1_W-1:0]     user1_o,
    output logic [`JTAG_USER2_W-1:0]     user2_o,
    output logic [`JTAG_USER3_W-1:0]     user3_o
);

    always_ff @(posedge tck_i or negedge trst_n_i) begin
        if (!trst_n_i) begin
            user0_o <= '0;
            user1_o <= '0;
            user2_o <= '0;
            user3_o <= '0;
        end else if (update_dr_i) begin
            case (opcode_i)
                jtag_dbg_pkg::USER0: user0_o <= shift_data_i[`JTAG_USER0_W-1:0];
                jtag_dbg_pkg::USER1: user1_o <= shift_data_i[`JTAG_USER1_W-1:0];
                jtag_dbg_pkg::USER2: user2_o <= shift_data_i[`JTAG_USER2_W-1:0];
                jtag_dbg_pkg::USER3: user3_o <= shift_data_i[`JTAG_USER3_W-1:0];
                default: ;                       // IDCODE and BYPASS write nothing
            endcase
        end
    end

    // Read mux, zero-extended to the DR width
    always_comb begin
        user_rd_data_o = '0;
        case (opcode_i)
            jtag_dbg_pkg::USER0: user_rd_data_o[`JTAG_USER0_W-1:0] = user0_o;
            jtag_dbg_pkg::USER1: user_rd_data_o[`JTAG_USER1_W-1:0] = user1_o;
            jtag_dbg_pkg::USER2: user_rd_data_o[`JTAG_USER2_W-1:0] = user2_o;
            jtag_dbg_pkg::USER3: user_rd_data_o[`JTAG_USER3_W-1:0] = user3_o;
            default:             user_rd_data_o = '0;
        endcase
    end

endmodule

//--- rtl/jtag_dbg_top.sv
// Single TCK domain. User outputs are not synchronized to any system clock
`timescale 1ns/1ps
`include "jtag_dbg_macros.svh"

module jtag_dbg_top (
    input  logic                     tck_i,
    input  logic                     trst_n_i,
    input  logic                     tms_i,
    input  logic                     tdi_i,
    output logic                     tdo_o,
    output logic [`JTAG_USER0_W-1:0] user0_o,
    output logic [`JTAG_USER1_W-1:0] user1_o,
    output logic [`JTAG_USER2_W-1:0] user2_o,
    output logic [`JTAG_USER3_W-1:0] user3_o
);

    //////////////////////////////////////////////////
    // TAP strobes
    logic logic_reset;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;

    // Instruction and data paths
    jtag_dbg_pkg::ir_opcode_e  opcode;
    logic                      ir_lsb;
    logic [`JTAG_DR_WIDTH-1:0] user_rd_data;
    logic [`JTAG_DR_WIDTH-1:0] shift_data;

    tap_fsm u_tap_fsm (
        .tck_i(tck_i), .trst_n_i(trst_n_i), .tms_i(tms_i),
        .logic_reset_o(logic_reset),
        .capture_ir_o(capture_ir), .shift_ir_o(shift_ir), .update_ir_o(update_ir),
        .capture_dr_o(capture_dr), .shift_dr_o(shift_dr), .update_dr_o(update_dr)
    );

    tap_ir u_tap_ir (
        .tck_i(tck_i), .trst_n_i(trst_n_i), .tdi_i(tdi_i),
        .logic_reset_i(logic_reset),
        .capture_ir_i(capture_ir), .shift_ir_i(shift_ir), .update_ir_i(update_ir),
        .ir_lsb_o(ir_lsb), .opcode_o(opcode)
    );

    tap_dr u_tap_dr (
        .tck_i(tck_i), .trst_n_i(trst_n_i), .tdi_i(tdi_i), .opcode_i(opcode),
        .capture_dr_i(capture_dr), .shift_dr_i(shift_dr),
        .shift_ir_i(shift_ir), .ir_lsb_i(ir_lsb),
        .user_rd_data_i(user_rd_data), .shift_data_o(shift_data), .tdo_o(tdo_o)
    );

    user_regs u_user_regs (
        .tck_i(tck_i), .trst_n_i(trst_n_i), .opcode_i(opcode),
        .update_dr_i(update_dr), .shift_data_i(shift_data),
        .user_rd_data_o(user_rd_data),
        .user0_o(user0_o), .user1_o(user1_o), .user2_o(user2_o), .user3_o(user3_o)
    );

endmodule

//--- bench/tb_jtag_dbg_top.sv
// Scans start and end in Run-Test/Idle. TDO is read 10 ns after each rise, before it can change
`timescale 1ns/1ps
`include "jtag_dbg_macros.svh"

module tb_jtag_dbg_top;

    localparam int EDGE_LIMIT = 300;         // ns allowed per TCK rise

    logic                     tck_i;
    logic                     trst_n_i;
    logic                     tms_i;
    logic                     tdi_i;
    logic                     tdo_o;
    logic [`JTAG_USER0_W-1:0] user0_o;
    logic [`JTAG_USER1_W-1:0] user1_o;
    logic [`JTAG_USER2_W-1:0] user2_o;
    logic [`JTAG_USER3_W-1:0] user3_o;

    logic [31:0] rng_state;
    logic [31:0] ir_model;                   // Raw IR contents, low 5 bits
    logic [31:0] user_model [4];
    int          rise_cnt;
    time         last_rise;
    int          test_errs;
    int          n_pass;
    int          n_fail;

    jtag_dbg_top uut (
        .tck_i(tck_i), .trst_n_i(trst_n_i), .tms_i(tms_i), .tdi_i(tdi_i), .tdo_o(tdo_o),
        .user0_o(user0_o), .user1_o(user1_o), .user2_o(user2_o), .user3_o(user3_o)
    );

    initial begin
        tck_i = 1'b0;
        forever #50 tck_i = ~tck_i;
    end

    always @(posedge tck_i) begin
        rise_cnt  = rise_cnt + 1;
        last_rise = $time;
    end

    //////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] low_mask(input int w);
        return (w >= 32) ? 32'hFFFF_FFFF : ((32'd1 << w) - 32'd1);
    endfunction

    function automatic int user_width(input int n);
        case (n)
            0:       return `JTAG_USER0_W;
            1:       return `JTAG_USER1_W;
            2:       return `JTAG_USER2_W;
            default: return `JTAG_USER3_W;
        endcase
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            $display("[PASS] %s", name);
            n_pass++;
        end else begin
            $display("[FAIL] %s, %0d mismatches", name, test_errs);
            n_fail++;
        end
        test_errs = 0;
    endtask

    // One TCK cycle, inputs set 10 ns after the previous rise
    task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
        int start;
        int waited;
        start  = rise_cnt;
        waited = 0;
        tms_i  = tms;
        tdi_i  = tdi;
        while (rise_cnt == start && waited < EDGE_LIMIT) begin
            #1;
            waited++;
        end
        if (rise_cnt == start) begin
            $display("Timeout: TCK did not rise within %0d ns", EDGE_LIMIT);
            $display("Some tests failed");
            $finish;
        end else begin
            #(last_rise + 10 - $time);
            tdo = tdo_o;                     // Still the value from the last falling edge
        end
    endtask

    task automatic shift_bits(input int first, input int last, input logic [31:0] din,
                              inout logic [31:0] dout);
        logic [31:0] d;
        logic        tdo_bit;
        d = din >> first;
        for (int i = first; i <= last; i++) begin
            tck_cycle(i == last, d[0], tdo_bit);   // TMS high on the last bit
            dout = dout | ({31'd0, tdo_bit} << i);
            d    = d >> 1;
        end
    endtask

    //////////////////////////////////////////////////
    // TAP sequences

    task automatic goto_reset();
        logic tdo_drop;
        repeat (5) tck_cycle(1'b1, 1'b0, tdo_drop);
        tck_cycle(1'b0, 1'b0, tdo_drop);           // Run-Test/Idle
        ir_model = 32'(jtag_dbg_pkg::IDCODE);
    endtask

    task automatic scan_ir(input logic [31:0] din);
        logic [31:0] dout;
        logic        tdo_drop;
        dout = '0;
        tck_cycle(1'b1, 1'b0, tdo_drop);           // Select-DR
        tck_cycle(1'b1, 1'b0, tdo_drop);           // Select-IR
        tck_cycle(1'b0, 1'b0, tdo_drop);
        tck_cycle(1'b0, 1'b0, tdo_drop);           // Shift-IR
        shift_bits(0, `JTAG_IR_WIDTH - 1, din, dout);
        tck_cycle(1'b1, 1'b0, tdo_drop);           // Update-IR
        tck_cycle(1'b0, 1'b0, tdo_drop);
        check(dout, ir_model, "IR readback");
        ir_model = din & low_mask(`JTAG_IR_WIDTH);
    endtask

    // split > 0 leaves Shift-DR after that many bits and idles in Pause-DR
    task automatic scan_dr(input int n, input logic [31:0] din, input int split,
                           input int pauses, output logic [31:0] dout);
        logic tdo_drop;
        dout = '0;
        tck_cycle(1'b1, 1'b0, tdo_drop);           // Select-DR
        tck_cycle(1'b0, 1'b0, tdo_drop);
        tck_cycle(1'b0, 1'b0, tdo_drop);           // Shift-DR
        if (split > 0) begin
            shift_bits(0, split - 1, din, dout);
            tck_cycle(1'b0, 1'b0, tdo_drop);       // Pause-DR
            repeat (pauses) tck_cycle(1'b0, 1'b0, tdo_drop);
            tck_cycle(1'b1, 1'b0, tdo_drop);       // Exit2-DR
            tck_cycle(1'b0, 1'b0, tdo_drop);
        end
        shift_bits(split, n - 1, din, dout);
        tck_cycle(1'b1, 1'b0, tdo_drop);           // Update-DR
        tck_cycle(1'b0, 1'b0, tdo_drop);
    endtask

    task automatic check_outputs();
        check({24'd0, user0_o}, user_model[0], "user0_o");
        check({16'd0, user1_o}, user_model[1], "user1_o");
        check({8'd0, user2_o}, user_model[2], "user2_o");
        check(user3_o, user_model[3], "user3_o");
    endtask

    task automatic user_access(input int n, input int split, input int pauses);
        logic [31:0] din;
        logic [31:0] dout;
        int          w;
        w   = user_width(n);
        din = xorshift();
        scan_ir(32'h10 + n);
        scan_dr(w, din, split, pauses, dout);
        check(dout, user_model[n], "user register readback");   // Old value comes out
        user_model[n] = din & low_mask(w);
        check_outputs();
    endtask

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] dout;
        logic [31:0] r;
        logic        tdo_drop;
        int          k;
        tms_i      = 1'b1;
        tdi_i      = 1'b0;
        trst_n_i   = 1'b0;
        rng_state  = 32'd16;
        user_model = '{default: '0};
        repeat (3) tck_cycle(1'b1, 1'b0, tdo_drop);
        trst_n_i = 1'b1;
        goto_reset();

        scan_dr(32, xorshift(), 0, 0, dout);
        check(dout, `JTAG_IDCODE, "IDCODE after TRST");
        scan_ir(xorshift() & 32'h1F);
        goto_reset();
        scan_dr(32, xorshift(), 0, 0, dout);
        check(dout, `JTAG_IDCODE, "IDCODE after TMS reset");
        end_test("IDCODE after reset");

        repeat (20) scan_ir(xorshift() & 32'h1F);
        end_test("IR readback");

        for (int i = 0; i < 8; i++) begin
            scan_ir((i == 0) ? 32'h1F : 32'h14 + (xorshift() % 32'd11));   // Unlisted codes
            k = 1 + (xorshift() % 32);
            r = xorshift();
            scan_dr(k, r, 0, 0, dout);
            check(dout, (r << 1) & low_mask(k), "bypass one-bit delay");
        end
        end_test("bypass");

        for (int i = 0; i < 12; i++) begin
            k = xorshift() % 4;
            user_access(k, 0, 0);
            user_access(k, 0, 0);
        end
        end_test("user registers");

        repeat (6) user_access(3, 1 + (xorshift() % 31), xorshift() % 5);
        end_test("pause resume");

        goto_reset();
        scan_dr(32, xorshift(), 0, 0, dout);
        check(dout, `JTAG_IDCODE, "IR after TMS reset");
        check_outputs();                     // Kept through Test-Logic-Reset
        trst_n_i = 1'b0;
        tck_cycle(1'b1, 1'b0, tdo_drop);
        trst_n_i   = 1'b1;
        user_model = '{default: '0};
        check_outputs();
        goto_reset();
        scan_ir(32'(jtag_dbg_pkg::IDCODE));
        end_test("reset scope");

        $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- jtag_dbg_top.f
+incdir+rtl
rtl/jtag_dbg_pkg.sv
rtl/tap_fsm.sv
rtl/tap_ir.sv
rtl/tap_dr.sv
rtl/user_regs.sv
rtl/jtag_dbg_top.sv
bench/tb_jtag_dbg_top.sv

//--- Makefile
# Verilator build of the JTAG debug port testbench, result read from the log

SRCS = $(filter-out +%,$(shell cat jtag_dbg_top.f))

.PHONY: run clean
.DELETE_ON_ERROR:

run: sim.log
	@cat sim.log
	@if grep -q "Some tests failed" sim.log; then echo "FAIL"; exit 1; fi
	@echo "PASS"

sim.log: obj_dir/Vtb_jtag_dbg_top
	./obj_dir/Vtb_jtag_dbg_top > sim.log

obj_dir/V%: $(SRCS) rtl/jtag_dbg_macros.svh jtag_dbg_top.f
	verilator --binary -f jtag_dbg_top.f --top-module $* -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log
